// File: filelist.f
verilog/fc_arith_pkg.sv
verilog/fc_array_pkg.sv
verilog/skew_line.sv
verilog/fc_decode.sv
verilog/fc_pe.sv
verilog/fc_execute.sv
verilog/fc_result.sv
verilog/fc_core.sv
verif/fc_core_assertions.sv
verif/fc_core_checker.sv
verif/fc_core_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the fc core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module fc_core_tb -f filelist.f -o fc_core_sim \
  || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/fc_core_sim +verilator+error+limit+1000)
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST RESULT: PASS" && echo "simulation ok" \
  || { echo "simulation reported failure"; exit 1; }

// File: verif/fc_core_tb.sv
// fc core testbench: clock, reset, directed and seeded random vectors, final report
`default_nettype none

module fc_core_tb;
  import fc_arith_pkg::*;
  import fc_array_pkg::*;

  localparam int RAND_VECTORS   = 40;
  localparam int MAX_VEC_STEPS  = 20;
  localparam int TIMEOUT_CYCLES = RAND_VECTORS * MAX_VEC_STEPS * 2 + 200;

  typedef logic [LANES*OPERAND_W-1:0] word_t;

  logic     clk;
  logic     rstn;
  logic     step;
  operand_t feat;
  word_t    weight;
  logic     first;
  logic     last;
  word_t    bias;
  logic     out_valid;
  word_t    out_data;
  int       check_errors;
  int       out_count;
  int       vectors_sent;
  int       cycles;
  int       total_errors;

  fc_core i_fc_core (
    .clk       (clk),
    .rstn      (rstn),
    .step      (step),
    .feat      (feat),
    .weight    (weight),
    .first     (first),
    .last      (last),
    .bias      (bias),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  fc_core_checker i_checker (
    .clk         (clk),
    .rstn        (rstn),
    .step        (step),
    .feat        (feat),
    .weight      (weight),
    .first       (first),
    .last        (last),
    .bias        (bias),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .error_count (check_errors),
    .out_count   (out_count)
  );

  bind fc_core fc_core_assertions i_assertions (
    .clk       (clk),
    .rstn      (rstn),
    .step      (step),
    .last      (last),
    .out_valid (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles with %0d of %0d outputs seen",
               cycles, out_count, vectors_sent);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic operand_t rand_operand();
    case ($urandom_range(0, 9))
      0:       return 8'sh80;   // -128, the odd magnitude
      1:       return 8'sh7f;
      2:       return 8'sh00;
      default: return operand_t'($urandom);
    endcase
  endfunction

  function automatic word_t rand_word();
    word_t w;
    for (int k = 0; k < LANES; k++) begin
      w[k*OPERAND_W +: OPERAND_W] = rand_operand();
    end
    return w;
  endfunction

  // one step, preceded by a random run of frozen cycles carrying junk
  task automatic apply_step(input operand_t f, input word_t w, input logic fl,
                            input logic ll, input word_t b);
    while ($urandom_range(0, 3) == 0) begin
      step   = 1'b0;
      feat   = rand_operand();
      weight = rand_word();
      bias   = rand_word();
      first  = 1'b0;
      last   = 1'b0;
      @(posedge clk);
      #1;
    end
    step   = 1'b1;
    feat   = f;
    weight = w;
    first  = fl;
    last   = ll;
    bias   = b;
    @(posedge clk);
    #1;
  endtask

  task automatic idle_step();
    apply_step(rand_operand(), rand_word(), 1'b0, 1'b0, rand_word());
  endtask

  task automatic send_fixed_vector(input operand_t f, input word_t w, input word_t b);
    for (int i = 0; i < MIN_VECTOR_STEPS; i++) begin
      apply_step(f, w, i == 0, i == MIN_VECTOR_STEPS - 1, b);
    end
    vectors_sent++;
  endtask

  task automatic send_random_vector(input int len);
    word_t b;
    b = rand_word();
    for (int i = 0; i < len; i++) begin
      apply_step(rand_operand(), rand_word(), i == 0, i == len - 1,
                 (i == len - 1) ? b : rand_word());   // bias only matters on last
    end
    vectors_sent++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(84));
    rstn         = 1'b0;
    step         = 1'b0;
    feat         = '0;
    weight       = '0;
    first        = 1'b0;
    last         = 1'b0;
    bias         = '0;
    vectors_sent = 0;
    repeat (4) @(posedge clk);
    #1;
    rstn = 1'b1;

    // negative, saturated and mid-range sums in every lane
    send_fixed_vector(8'sh7f, {LANES{8'h80}}, {LANES{8'h7f}});
    send_fixed_vector(8'sh7f, {LANES{8'h7f}}, {LANES{8'h00}});
    send_fixed_vector(8'sd10, 32'h32281e14, 32'h05fb05fb);

    for (int v = 0; v < RAND_VECTORS; v++) begin
      send_random_vector($urandom_range(MIN_VECTOR_STEPS, MAX_VEC_STEPS));
      repeat ($urandom_range(0, 2)) idle_step();
    end

    while (out_count < vectors_sent) begin
      idle_step();
    end
    repeat (MIN_VECTOR_STEPS) idle_step();   // catch stray strobes

    total_errors = check_errors + i_fc_core.i_assertions.fail_count;
    if (out_count != vectors_sent) begin
      $display("output count %0d does not match %0d vectors sent", out_count, vectors_sent);
      total_errors++;
    end
    $display("errors %0d (checker %0d, assertions %0d), outputs %0d of %0d", total_errors,
             check_errors, i_fc_core.i_assertions.fail_count, out_count, vectors_sent);
    if (total_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/fc_core_checker.sv
// fc core checker: reference model of the layer slice, checks output words and strobe timing
`default_nettype none

module fc_core_checker (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   step,
  input  fc_arith_pkg::operand_t feat,
  input  logic [fc_array_pkg::LANES*fc_arith_pkg::OPERAND_W-1:0] weight,
  input  logic                   first,
  input  logic                   last,
  input  logic [fc_array_pkg::LANES*fc_arith_pkg::OPERAND_W-1:0] bias,
  input  logic                   out_valid,
  input  logic [fc_array_pkg::LANES*fc_arith_pkg::OPERAND_W-1:0] out_data,
  output int                     error_count,
  output int                     out_count
);
  import fc_arith_pkg::*;
  import fc_array_pkg::*;

  typedef logic [LANES*OPERAND_W-1:0] word_t;

  int    acc [LANES];       // running dot product per neuron
  word_t expect_q [$];      // packed words still owed by the DUT
  int    countdown_q [$];   // steps left before each strobe
  logic  valid_due;

  // negative to zero, past bit 12 to the clip value
  function automatic logic [OPERAND_W-1:0] clip_lane(input int total);
    if (total < 0) begin
      return '0;
    end
    if (total >= (1 << (QUANT_MSB + 1))) begin
      return OPERAND_W'(QUANT_MAX);
    end
    return OPERAND_W'(total >>> QUANT_LSB);
  endfunction

  function automatic word_t model_word(input word_t bias_word);
    word_t w;
    for (int k = 0; k < LANES; k++) begin
      w[k*OPERAND_W +: OPERAND_W] =
        clip_lane(acc[k] + int'(operand_t'(bias_word[k*OPERAND_W +: OPERAND_W])));
    end
    return w;
  endfunction

  always @(posedge clk) begin
    int    prod;
    word_t exp_word;
    logic  due;
    if (!rstn) begin
      valid_due   = 1'b0;
      error_count = 0;
      out_count   = 0;
      expect_q.delete();
      countdown_q.delete();
    end else begin
      // out_valid seen here was set at the previous edge
      if (out_valid !== valid_due) begin
        $display("[ERROR] t=%0t out_valid expected %b actual %b", $time, valid_due, out_valid);
        error_count++;
      end
      if (out_valid === 1'b1) begin
        out_count++;
        if (expect_q.size() == 0) begin
          $display("[ERROR] t=%0t output strobe with no vector outstanding", $time);
          error_count++;
        end else begin
          exp_word = expect_q.pop_front();
          if (out_data !== exp_word) begin
            $display("[ERROR] t=%0t out_data expected %h actual %h", $time, exp_word, out_data);
            error_count++;
          end
        end
      end
      due = 1'b0;
      if (step) begin   // frozen cycles count for nothing
        foreach (countdown_q[i]) begin
          countdown_q[i]--;
        end
        if (countdown_q.size() > 0 && countdown_q[0] == 0) begin
          void'(countdown_q.pop_front());
          due = 1'b1;
        end
        for (int k = 0; k < LANES; k++) begin
          prod   = int'(feat) * int'(operand_t'(weight[k*OPERAND_W +: OPERAND_W]));
          acc[k] = first ? prod : acc[k] + prod;
        end
        if (last) begin
          expect_q.push_back(model_word(bias));
          countdown_q.push_back(OUT_LATENCY);
        end
      end
      valid_due = due;
    end
  end

endmodule

`default_nettype wire

// File: verif/fc_core_assertions.sv
// fc core assertions: strobe shape, freeze behaviour and last spacing at the top level ports
`default_nettype none

module fc_core_assertions (
  input logic clk,
  input logic rstn,
  input logic step,
  input logic last,
  input logic out_valid
);
  import fc_array_pkg::*;

  int gap;          // steps since the previous last, saturating
  int fail_count;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      gap <= MIN_VECTOR_STEPS;
    end else if (step) begin
      if (last) begin
        gap <= 1;
      end else if (gap < MIN_VECTOR_STEPS) begin
        gap <= gap + 1;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) !rstn |=> !out_valid)
    else begin
      $error("out_valid high right after a reset cycle");
      fail_count++;
    end

  a_single_pulse: assert property (@(posedge clk) disable iff (!rstn) out_valid |=> !out_valid)
    else begin
      $error("out_valid stayed high for two cycles");
      fail_count++;
    end

  a_frozen_quiet: assert property (@(posedge clk) disable iff (!rstn) !step |=> !out_valid)
    else begin
      $error("out_valid rose after a cycle without step");
      fail_count++;
    end

  a_last_spacing: assert property (@(posedge clk) disable iff (!rstn)
    step && last |-> gap >= MIN_VECTOR_STEPS)
    else begin
      $error("last strobes closer than the minimum vector length");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: verilog/fc_core.sv
// fc core: four neuron fully connected slice, decode to element array to requantized output
`default_nettype none

module fc_core (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   step,
  input  fc_arith_pkg::operand_t feat,
  input  logic [fc_array_pkg::LANES*fc_arith_pkg::OPERAND_W-1:0] weight,
  input  logic                   first,
  input  logic                   last,
  input  logic [fc_array_pkg::LANES*fc_arith_pkg::OPERAND_W-1:0] bias,
  output logic                   out_valid,
  output logic [fc_array_pkg::LANES*fc_arith_pkg::OPERAND_W-1:0] out_data
);
  import fc_arith_pkg::*;
  import fc_array_pkg::*;

  operand_t                   lane_weight [LANES];
  logic [LANES-1:0]           lane_first;
  logic [LANES-1:0]           lane_last;
  logic [LANES-1:0]           lane_last_done;
  acc_t                       lane_sum    [LANES];
  logic [LANES*OPERAND_W-1:0] bias_held;

  fc_decode i_decode (
    .clk         (clk),
    .rstn        (rstn),
    .step        (step),
    .first       (first),
    .last        (last),
    .weight      (weight),
    .bias        (bias),
    .lane_weight (lane_weight),
    .lane_first  (lane_first),
    .lane_last   (lane_last),
    .bias_held   (bias_held)
  );

  fc_execute i_execute (
    .clk            (clk),
    .rstn           (rstn),
    .step           (step),
    .feat           (feat),
    .lane_weight    (lane_weight),
    .lane_first     (lane_first),
    .lane_last      (lane_last),
    .lane_sum       (lane_sum),
    .lane_last_done (lane_last_done)
  );

  fc_result i_result (
    .clk            (clk),
    .rstn           (rstn),
    .step           (step),
    .lane_sum       (lane_sum),
    .lane_last_done (lane_last_done),
    .bias_held      (bias_held),
    .out_valid      (out_valid),
    .out_data       (out_data)
  );

endmodule

`default_nettype wire

// File: verilog/fc_result.sv
// fc result: collects lane sums, adds bias, clips to 7 bits and strobes the packed word
`default_nettype none

module fc_result (
  input  logic               clk,
  input  logic               rstn,
  input  logic               step,
  input  fc_arith_pkg::acc_t lane_sum [fc_array_pkg::LANES],
  input  logic [fc_array_pkg::LANES-1:0] lane_last_done,
  input  logic [fc_array_pkg::LANES*fc_arith_pkg::OPERAND_W-1:0] bias_held,
  output logic               out_valid,
  output logic [fc_array_pkg::LANES*fc_arith_pkg::OPERAND_W-1:0] out_data
);
  import fc_arith_pkg::*;
  import fc_array_pkg::*;

  acc_t                       sum_q      [LANES-1];   // early lanes wait for the last one
  acc_t                       lane_final [LANES];
  acc_t                       biased     [LANES];
  logic [LANES*OPERAND_W-1:0] result_word;
  logic                       emit;

  assign emit = step && lane_last_done[LANES-1];

  always_ff @(posedge clk) begin
    for (int k = 0; k < LANES-1; k++) begin
      if (step && lane_last_done[k]) begin
        sum_q[k] <= lane_sum[k];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bias and requantization
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int k = 0; k < LANES-1; k++) begin
      lane_final[k] = sum_q[k];
    end
    lane_final[LANES-1] = lane_sum[LANES-1];   // last lane taken live
    for (int k = 0; k < LANES; k++) begin
      // bias byte is signed, extend before the add
      biased[k] = lane_final[k] + acc_t'(operand_t'(bias_held[k*OPERAND_W +: OPERAND_W]));
      if (biased[k][ACC_W-1]) begin
        result_word[k*OPERAND_W +: OPERAND_W] = '0;
      end else if (|biased[k][ACC_W-2:QUANT_MSB+1]) begin
        result_word[k*OPERAND_W +: OPERAND_W] = OPERAND_W'(QUANT_MAX);   // saturate
      end else begin
        result_word[k*OPERAND_W +: OPERAND_W] = OPERAND_W'(biased[k][QUANT_MSB:QUANT_LSB]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      out_data <= result_word;
    end
  end

  // one cycle strobe, a frozen step keeps it low
  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= emit;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fc_execute.sv
// fc execute: chain of elements passing the feature along, with last flag tracking
`default_nettype none

module fc_execute (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   step,
  input  fc_arith_pkg::operand_t feat,
  input  fc_arith_pkg::operand_t lane_weight [fc_array_pkg::LANES],
  input  logic [fc_array_pkg::LANES-1:0] lane_first,
  input  logic [fc_array_pkg::LANES-1:0] lane_last,
  output fc_arith_pkg::acc_t     lane_sum [fc_array_pkg::LANES],
  output logic [fc_array_pkg::LANES-1:0] lane_last_done
);
  import fc_arith_pkg::*;
  import fc_array_pkg::*;

  operand_t              feat_link [LANES+1];   // feature between neighbours
  logic [PE_LATENCY-1:0] last_pipe [LANES];     // last flag, matched to the element depth

  assign feat_link[0] = feat;

  for (genvar k = 0; k < LANES; k++) begin : g_elem
    fc_pe i_pe (
      .clk      (clk),
      .rstn     (rstn),
      .step     (step),
      .first    (lane_first[k]),
      .feat_in  (feat_link[k]),
      .weight   (lane_weight[k]),
      .feat_out (feat_link[k+1]),
      .sum      (lane_sum[k])
    );

    always_ff @(posedge clk) begin
      if (!rstn) begin
        last_pipe[k] <= '0;
      end else if (step) begin
        last_pipe[k] <= {last_pipe[k][PE_LATENCY-2:0], lane_last[k]};
      end
    end

    // high while lane_sum[k] holds the finished vector
    assign lane_last_done[k] = last_pipe[k][PE_LATENCY-1];
  end

endmodule

`default_nettype wire

// File: verilog/fc_pe.sv
// fc processing element: pipelined signed 8x8 multiply, 28-bit accumulate, feature forward
`default_nettype none

module fc_pe (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   step,
  input  logic                   first,
  input  fc_arith_pkg::operand_t feat_in,
  input  fc_arith_pkg::operand_t weight,
  output fc_arith_pkg::operand_t feat_out,
  output fc_arith_pkg::acc_t     sum
);
  import fc_arith_pkg::*;
  import fc_array_pkg::*;

  logic [OPERAND_W-1:0]  a_mag;
  logic [OPERAND_W-1:0]  b_mag;
  logic [OPERAND_W-1:0]  pp     [OPERAND_W];   // partial products
  logic [OPERAND_W-1:0]  pp_q   [OPERAND_W];
  logic [5:0]            lo2    [4];
  logic [5:0]            lo2_q  [4];
  logic [2:0]            hi2e_q [4];
  logic [3:0]            hi2o_q [4];
  logic [4:0]            hi3    [4];
  logic [9:0]            s3_q   [4];
  logic [7:0]            lo4    [2];
  logic [7:0]            lo4_q  [2];
  logic [2:0]            hi4e_q [2];
  logic [4:0]            hi4o_q [2];
  logic [4:0]            hi5    [2];
  logic [11:0]           s5_q   [2];
  logic [9:0]            lo6;
  logic [9:0]            lo6_q;
  logic [2:0]            hi6e_q;
  logic [6:0]            hi6o_q;
  logic [6:0]            hi7;
  logic [15:0]           mag;
  logic [15:0]           mag_q;
  product_t              prod_q;
  acc_t                  acc_base;
  logic [MUL_STAGES-1:1] sign_q;    // product sign, stages 1..7
  logic [MUL_STAGES:1]   first_q;   // first flag rides along to the accumulator

  // stage 1 operands as magnitudes, -128 maps to 128
  assign a_mag = feat_in[OPERAND_W-1] ? -feat_in : feat_in;
  assign b_mag = weight[OPERAND_W-1] ? -weight : weight;

  ////////////////////////////////////////////////////////////////////////////
  // reduction tree, low half added first and its carry folded into the high half
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < OPERAND_W; i++) begin
      pp[i] = b_mag[i] ? a_mag : '0;
    end
    for (int j = 0; j < 4; j++) begin   // pairs of partial products, shift 1
      lo2[j] = {1'b0, pp_q[2*j][4:0]} + {1'b0, pp_q[2*j+1][3:0], 1'b0};
      hi3[j] = {2'b0, hi2e_q[j]} + {1'b0, hi2o_q[j]} + {4'b0, lo2_q[j][5]};
    end
    for (int m = 0; m < 2; m++) begin   // shift 2
      lo4[m] = {1'b0, s3_q[2*m][6:0]} + {1'b0, s3_q[2*m+1][4:0], 2'b0};
      hi5[m] = {2'b0, hi4e_q[m]} + hi4o_q[m] + {4'b0, lo4_q[m][7]};
    end
    lo6 = {1'b0, s5_q[0][8:0]} + {1'b0, s5_q[1][4:0], 4'b0};   // shift 4
    hi7 = {4'b0, hi6e_q} + hi6o_q + {6'b0, lo6_q[9]};
    mag = {hi7, lo6_q[8:0]};
  end

  assign acc_base = first_q[MUL_STAGES] ? '0 : sum;   // first element restarts the sum

  // datapath registers
  always_ff @(posedge clk) begin
    if (step) begin
      feat_out <= feat_in;
      pp_q     <= pp;
      for (int j = 0; j < 4; j++) begin
        lo2_q[j]  <= lo2[j];
        hi2e_q[j] <= pp_q[2*j][7:5];
        hi2o_q[j] <= pp_q[2*j+1][7:4];
        s3_q[j]   <= {hi3[j], lo2_q[j][4:0]};
      end
      for (int m = 0; m < 2; m++) begin
        lo4_q[m]  <= lo4[m];
        hi4e_q[m] <= s3_q[2*m][9:7];
        hi4o_q[m] <= s3_q[2*m+1][9:5];
        s5_q[m]   <= {hi5[m], lo4_q[m][6:0]};
      end
      lo6_q  <= lo6;
      hi6e_q <= s5_q[0][11:9];
      hi6o_q <= s5_q[1][11:5];
      mag_q  <= mag;
      prod_q <= sign_q[MUL_STAGES-1] ? -product_t'(mag_q) : product_t'(mag_q);
      sum    <= acc_base + acc_t'(prod_q);   // stage 9
    end
  end

  // control flags
  always_ff @(posedge clk) begin
    if (!rstn) begin
      sign_q  <= '0;
      first_q <= '0;
    end else if (step) begin
      sign_q  <= {sign_q[MUL_STAGES-2:1], feat_in[OPERAND_W-1] ^ weight[OPERAND_W-1]};
      first_q <= {first_q[MUL_STAGES-1:1], first};
    end
  end

endmodule

`default_nettype wire

// File: verilog/fc_decode.sv
// fc decode: skews weights and flags per lane to meet the forwarded feature, holds bias
`default_nettype none

module fc_decode (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   step,
  input  logic                   first,
  input  logic                   last,
  input  logic [fc_array_pkg::LANES*fc_arith_pkg::OPERAND_W-1:0] weight,
  input  logic [fc_array_pkg::LANES*fc_arith_pkg::OPERAND_W-1:0] bias,
  output fc_arith_pkg::operand_t lane_weight [fc_array_pkg::LANES],
  output logic [fc_array_pkg::LANES-1:0] lane_first,
  output logic [fc_array_pkg::LANES-1:0] lane_last,
  output logic [fc_array_pkg::LANES*fc_arith_pkg::OPERAND_W-1:0] bias_held
);
  import fc_arith_pkg::*;
  import fc_array_pkg::*;

  typedef logic [LANES*OPERAND_W-1:0] bias_group_t;

  bias_group_t bias_skew;   // bias word aligned to the last lane

  ////////////////////////////////////////////////////////////////////////////
  // per lane skew, lane k trails the input by k steps
  ////////////////////////////////////////////////////////////////////////////
  for (genvar k = 0; k < LANES; k++) begin : g_lane
    skew_line #(.payload_t(operand_t), .DEPTH(k)) i_weight_skew (
      .clk  (clk),
      .rstn (rstn),
      .step (step),
      .din  (operand_t'(weight[k*OPERAND_W +: OPERAND_W])),
      .dout (lane_weight[k])
    );

    skew_line #(.payload_t(logic), .DEPTH(k)) i_first_skew (
      .clk  (clk),
      .rstn (rstn),
      .step (step),
      .din  (first),
      .dout (lane_first[k])
    );

    skew_line #(.payload_t(logic), .DEPTH(k)) i_last_skew (
      .clk  (clk),
      .rstn (rstn),
      .step (step),
      .din  (last),
      .dout (lane_last[k])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // bias, follows the last lane and is latched with its last flag
  ////////////////////////////////////////////////////////////////////////////
  skew_line #(.payload_t(bias_group_t), .DEPTH(LANES-1)) i_bias_skew (
    .clk  (clk),
    .rstn (rstn),
    .step (step),
    .din  (bias),
    .dout (bias_skew)
  );

  always_ff @(posedge clk) begin
    if (step && lane_last[LANES-1]) begin
      bias_held <= bias_skew;   // stays put until the next vector closes
    end
  end

endmodule

`default_nettype wire

// File: verilog/skew_line.sv
// step-enabled delay line of configurable depth for an arbitrary payload type
`default_nettype none

module skew_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     step,
  input  payload_t din,
  output payload_t dout
);

  if (DEPTH == 0) begin : g_pass
    assign dout = din;   // lane 0 needs no alignment
  end else begin : g_regs
    payload_t stage_q [DEPTH];

    always_ff @(posedge clk) begin
      if (!rstn) begin
        for (int i = 0; i < DEPTH; i++) begin
          stage_q[i] <= '0;
        end
      end else if (step) begin
        stage_q[0] <= din;
        for (int i = 1; i < DEPTH; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign dout = stage_q[DEPTH-1];
  end

endmodule

`default_nettype wire

// File: verilog/fc_array_pkg.sv
// fc element array geometry: lane count, multiplier depth and step latencies
`default_nettype none

package fc_array_pkg;

  localparam int LANES = 4;   // output neurons, one element each

  // multiplier stages, operands in to signed product out
  localparam int MUL_STAGES = 8;

  // plus one accumulate stage
  localparam int PE_LATENCY = MUL_STAGES + 1;

  // last lane sees its feature LANES-1 steps late
  localparam int OUT_LATENCY = (LANES - 1) + PE_LATENCY;

  // result stage holds lanes 0..2 until lane 3 lands, so vectors may not overlap there
  localparam int MIN_VECTOR_STEPS = OUT_LATENCY + 1;

endpackage

`default_nettype wire

// File: verilog/fc_arith_pkg.sv
// fc arithmetic formats: operand, product and accumulator types, requantization window
`default_nettype none

package fc_arith_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // operand and accumulator widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int OPERAND_W = 8;    // feature, weight and bias bytes
  localparam int ACC_W     = 28;   // room for long vectors of full scale products

  typedef logic signed [OPERAND_W-1:0]   operand_t;
  typedef logic signed [2*OPERAND_W-1:0] product_t;   // 8x8 signed product
  typedef logic signed [ACC_W-1:0]       acc_t;

  ////////////////////////////////////////////////////////////////////////////
  // requantization
  ////////////////////////////////////////////////////////////////////////////
  // output byte keeps sum bits QUANT_MSB down to QUANT_LSB
  // negative sums clip to zero, anything above the window to QUANT_MAX
  localparam int QUANT_LSB = 6;
  localparam int QUANT_MSB = 12;
  localparam int QUANT_MAX = 127;

endpackage

`default_nettype wire
